// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
    input  logic    [XLEN-1:0] a_i,
    input  logic    [XLEN-1:0] b_i,
    input  alu_op_e            op_i,
    output logic    [XLEN-1:0] result_o,
    output logic               eq_o      // For BEQ and BNE
);

    logic slt;

    // Signed less-than
    assign slt = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, slt}; // 0 or 1
            default: result_o = '0;
        endcase
    end

    assign eq_o = (a_i == b_i);

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_pkg::*; (
    input  logic            [XLEN-1:0] instr_i,
    input  logic                       valid_i,
    output logic                       reg_we_o,
    output alu_op_e                    alu_op_o,
    output a_sel_e                     a_sel_o,
    output logic                       b_imm_o,     // Operand B is the immediate
    output wb_sel_e                    wb_sel_o,
    output logic                       branch_o,
    output logic                       branch_ne_o, // BNE, else BEQ
    output logic                       jump_o,
    output logic                       jalr_o,
    output logic            [XLEN-1:0] imm_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_fmt_e   imm_fmt;
    logic       we_d;
    logic       br_d;
    logic       jmp_d;
    logic       jalr_d;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // Default is a no-op that still retires
        we_d        = 1'b0;
        br_d        = 1'b0;
        jmp_d       = 1'b0;
        jalr_d      = 1'b0;
        alu_op_o    = ALU_ADD;
        a_sel_o     = A_REG;
        b_imm_o     = 1'b0;
        wb_sel_o    = WB_ALU;
        branch_ne_o = 1'b0;
        imm_fmt     = IMM_I;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                b_imm_o = (opcode == OPC_OP_IMM);
                we_d    = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b111: alu_op_o = ALU_AND;
                    3'b110: alu_op_o = ALU_OR;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b010: begin
                        alu_op_o = ALU_SLT;
                        we_d     = (opcode == OPC_OP); // SLTI outside the subset
                    end
                    default: we_d = 1'b0; // Shifts etc. not supported
                endcase
            end
            OPC_LUI: begin
                we_d    = 1'b1;
                a_sel_o = A_ZERO; // 0 + imm
                b_imm_o = 1'b1;
                imm_fmt = IMM_U;
            end
            OPC_AUIPC: begin
                we_d    = 1'b1;
                a_sel_o = A_PC;   // pc + imm
                b_imm_o = 1'b1;
                imm_fmt = IMM_U;
            end
            OPC_BRANCH: begin
                br_d        = (funct3 == 3'b000) || (funct3 == 3'b001);
                branch_ne_o = funct3[0];
                alu_op_o    = ALU_SUB; // Result unused, eq flag decides
                imm_fmt     = IMM_B;
            end
            OPC_JAL: begin
                we_d     = 1'b1;
                jmp_d    = 1'b1;
                wb_sel_o = WB_PC4;
                imm_fmt  = IMM_J;
            end
            OPC_JALR: begin
                we_d     = 1'b1;
                jmp_d    = 1'b1;
                jalr_d   = 1'b1; // Target from rs1
                wb_sel_o = WB_PC4;
            end
            default: ;
        endcase
    end

    // Sign-extended immediates
    always_comb begin
        case (imm_fmt)
            IMM_U:   imm_o = {instr_i[31:12], 12'b0};
            IMM_B:   imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                              instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J:   imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                              instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = {{20{instr_i[31]}}, instr_i[31:20]}; // I-type
        endcase
    end

    // Side effects only for a valid instruction
    assign reg_we_o = valid_i & we_d;
    assign branch_o = valid_i & br_d;
    assign jump_o   = valid_i & jmp_d;
    assign jalr_o   = valid_i & jalr_d;

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            run_i,         // Trigger latched
    input  logic            redirect_i,    // Taken branch or jump in execute
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic [XLEN-1:0] instr_i,       // From instr_mem
    output logic [XLEN-1:0] pc_o,          // Fetch address
    output logic            ex_valid_o,
    output logic [XLEN-1:0] ex_pc_o,
    output logic [XLEN-1:0] ex_instr_o
);

    logic [XLEN-1:0] pc_next;

    // Sequential or redirected
    assign pc_next = redirect_i ? redirect_pc_i : pc_o + XLEN'(4);

    // PC held at 0 until started
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o <= '0;
        end else if (run_i) begin
            pc_o <= pc_next;
        end
    end

    // Valid bit of the fetch/execute register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= run_i && !redirect_i; // Flush the wrong-path fetch
        end
    end

    // Payload, no reset needed
    always_ff @(posedge clk) begin
        if (run_i) begin
            ex_pc_o    <= pc_o;
            ex_instr_o <= instr_i;
        end
    end

    // Redirects only come from a real instruction
    a_redirect_needs_valid: assert property (
        @(posedge clk) disable iff (rst)
        redirect_i |-> ex_valid_o
    ) else $error("fetch_stage: redirect without valid instruction");

    // One bubble, then the target reaches execute
    a_bubble_after_redirect: assert property (
        @(posedge clk) disable iff (rst)
        redirect_i |=> !ex_valid_o ##1 (ex_valid_o && ex_pc_o == $past(redirect_pc_i, 2))
    ) else $error("fetch_stage: wrong-path instruction not flushed");

endmodule

`default_nettype wire

// ==== hdl/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               run_i,        // Core started
    // Program load port
    input  logic               prog_valid_i,
    input  logic [IMEM_AW-1:0] prog_addr_i,  // Word address
    input  logic [XLEN-1:0]    prog_data_i,
    output logic               prog_ready_o,
    // Fetch read port
    input  logic [XLEN-1:0]    addr_i,       // Byte address from PC
    output logic [XLEN-1:0]    instr_o
);

    logic [XLEN-1:0]    mem [IMEM_DEPTH]; // Program storage, no reset
    logic [IMEM_AW-1:0] rd_word;

    // Loading only allowed before start
    assign prog_ready_o = ~run_i;

    // Write on handshake
    always_ff @(posedge clk) begin
        if (prog_valid_i && prog_ready_o) begin
            mem[prog_addr_i] <= prog_data_i;
        end
    end

    // Drop byte offset, upper bits wrap
    assign rd_word = addr_i[IMEM_AW+1:2];
    assign instr_o = mem[rd_word]; // Async read

    // Offered word left untouched once the core runs
    a_no_write_while_running: assert property (
        @(posedge clk) disable iff (rst)
        run_i |=> mem[$past(prog_addr_i)] == $past(mem[prog_addr_i])
    ) else $error("instr_mem: program word changed while core running");

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    input  logic [4:0]      rd_i,
    input  logic            we_i,
    input  logic [XLEN-1:0] wd_i,
    output logic [XLEN-1:0] rd1_o,
    output logic [XLEN-1:0] rd2_o,
    output logic [XLEN-1:0] a0_o   // x10 tap for the top level
);

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage

    // Writes to x0 dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Combinational reads
    always_comb begin
        rd1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
        rd2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];
    end

    assign a0_o = regs[10];

endmodule

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               trigger_i,
    // Program load port
    input  logic               prog_valid_i,
    input  logic [IMEM_AW-1:0] prog_addr_i,
    input  logic [XLEN-1:0]    prog_data_i,
    output logic               prog_ready_o,
    // Architectural view
    output logic [XLEN-1:0]    a0_o,
    output logic               retire_o,
    output logic [XLEN-1:0]    retire_pc_o
);

    logic            run;          // Trigger latch
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] fetch_instr;
    logic            ex_valid;
    logic [XLEN-1:0] ex_pc;
    logic [XLEN-1:0] ex_instr;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    // Decoded controls
    logic            reg_we;
    alu_op_e         alu_op;
    a_sel_e          a_sel;
    logic            b_imm;
    wb_sel_e         wb_sel;
    logic            branch;
    logic            branch_ne;
    logic            jump;
    logic            jalr;
    logic [XLEN-1:0] imm;
    // Execute datapath
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_eq;
    logic            taken;
    logic [XLEN-1:0] wb_data;

    // Trigger seen during reset also starts the core
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= trigger_i;
        end else if (trigger_i) begin
            run <= 1'b1; // Sticky until reset
        end
    end

    instr_mem instr_mem_inst (
        .clk          (clk),
        .rst          (rst),
        .run_i        (run),
        .prog_valid_i (prog_valid_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .prog_ready_o (prog_ready_o),
        .addr_i       (fetch_pc),
        .instr_o      (fetch_instr)
    );

    fetch_stage fetch_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .run_i         (run),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .instr_i       (fetch_instr),
        .pc_o          (fetch_pc),
        .ex_valid_o    (ex_valid),
        .ex_pc_o       (ex_pc),
        .ex_instr_o    (ex_instr)
    );

    decoder decoder_inst (
        .instr_i     (ex_instr),
        .valid_i     (ex_valid),
        .reg_we_o    (reg_we),
        .alu_op_o    (alu_op),
        .a_sel_o     (a_sel),
        .b_imm_o     (b_imm),
        .wb_sel_o    (wb_sel),
        .branch_o    (branch),
        .branch_ne_o (branch_ne),
        .jump_o      (jump),
        .jalr_o      (jalr),
        .imm_o       (imm)
    );

    // Register block next to the ALU it feeds
    register_file register_file_inst (
        .clk   (clk),
        .rst   (rst),
        .rs1_i (ex_instr[19:15]),
        .rs2_i (ex_instr[24:20]),
        .rd_i  (ex_instr[11:7]),
        .we_i  (reg_we),      // Already gated by ex_valid
        .wd_i  (wb_data),
        .rd1_o (rd1),
        .rd2_o (rd2),
        .a0_o  (a0_o)
    );

    // Operand A: rs1, PC for AUIPC, zero for LUI
    always_comb begin
        case (a_sel)
            A_REG:   op_a = rd1;
            A_PC:    op_a = ex_pc;
            default: op_a = '0;
        endcase
    end

    assign op_b = b_imm ? imm : rd2;

    alu alu_inst (
        .a_i      (op_a),
        .b_i      (op_b),
        .op_i     (alu_op),
        .result_o (alu_result),
        .eq_o     (alu_eq)
    );

    // BEQ on equal, BNE on not equal
    assign taken    = branch & (alu_eq ^ branch_ne);
    assign redirect = taken | jump;

    // JALR clears bit 0 of rs1 + imm
    assign redirect_pc = jalr ? ((rd1 + imm) & ~XLEN'(1)) : ex_pc + imm;

    assign wb_data = (wb_sel == WB_PC4) ? ex_pc + XLEN'(4) : alu_result;

    // One pulse per executed instruction
    assign retire_o    = ex_valid;
    assign retire_pc_o = ex_pc;

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Instruction memory geometry
    localparam int IMEM_DEPTH = 64;            // Words
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH); // Word address bits

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // Register-register ALU
        OPC_OP_IMM = 7'b0010011, // Register-immediate ALU
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011, // BEQ and BNE only
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5  // Signed compare
    } alu_op_e;

    // Immediate layouts
    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_U = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } imm_fmt_e;

    // Operand A source
    typedef enum logic [1:0] {
        A_REG  = 2'd0, // rs1
        A_PC   = 2'd1, // AUIPC
        A_ZERO = 2'd2  // LUI
    } a_sel_e;

    // Write-back source
    typedef enum logic [0:0] {
        WB_ALU = 1'b0,
        WB_PC4 = 1'b1  // Link value of JAL and JALR
    } wb_sel_e;

endpackage

`default_nettype wire

// ==== rv_core_top.f ====
hdl/rv_pkg.sv
hdl/instr_mem.sv
hdl/fetch_stage.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/rv_core_top.sv
test/clk_gen.sv
test/tb_rv_core_top.sv

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o; // Free running, 50 % duty

endmodule

`default_nettype wire

// ==== test/tb_rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core_top;

    localparam int IMEM_WORDS = 64;  // Own copy of the memory depth
    localparam int CLK_NS     = 8;
    localparam int RST_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic        trigger_i;
    logic        prog_valid_i;
    logic [5:0]  prog_addr_i;
    logic [31:0] prog_data_i;
    logic        prog_ready_o;
    logic [31:0] a0_o;
    logic        retire_o;
    logic [31:0] retire_pc_o;

    logic [31:0] prog [IMEM_WORDS];   // Program image, also read by the model
    logic        landed [IMEM_WORDS]; // Slot is a branch or jump target
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic        model_redirect;      // Last model instruction changed flow
    logic [31:0] rng_state;
    logic [31:0] halt_pc;
    int          prog_len;
    int          timeout_ns;
    int          error_count;

    clk_gen #(.PERIOD_NS(CLK_NS)) clk_gen_inst (.clk_o(clk));

    rv_core_top rv_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .trigger_i    (trigger_i),
        .prog_valid_i (prog_valid_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .prog_ready_o (prog_ready_o),
        .a0_o         (a0_o),
        .retire_o     (retire_o),
        .retire_pc_o  (retire_pc_o)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'((r >> 8) % n); // Low LCG bits are weak
    endfunction

    // RV32I encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Forward-only random program, JAL-to-self at the end
    task automatic build_program();
        int          i;
        int          room;
        int          lim;
        int          t;
        int          kind;
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rx;
        logic [31:0] r;
        prog_len = 40 + rand_below(21);
        halt_pc  = 32'((prog_len - 1) * 4);
        for (int a = 0; a < IMEM_WORDS; a++) begin
            prog[a]   = {6'(a), 6'(a), 5'd0, 3'b000, 5'd0, 7'h13}; // ADDI x0 filler
            landed[a] = 1'b0;
        end
        i = 0;
        while (i < prog_len - 1) begin
            room = prog_len - 1 - i;              // Slots before the halt
            kind = rand_below(16);
            sel  = rand_below(6);
            rd   = 5'(rand_below(16));
            rs1  = 5'(rand_below(16));
            rs2  = 5'(rand_below(16));
            r    = lcg_next();
            if (kind == 14 && room >= 3 && !landed[i+1] && !landed[i+2]) begin
                rx  = 5'(1 + rand_below(15));
                lim = (room - 2 < 4) ? room - 2 : 4;
                t   = i + 2 + 1 + rand_below(lim);
                prog[i]   = {20'h0, rx, 7'h37};                                 // LUI rx, 0
                prog[i+1] = enc_i(12'(t * 4 + rand_below(2)), rx, 3'b000, rx, 7'h13);
                prog[i+2] = enc_i(12'h0, rx, 3'b000, rd, 7'h67);                // JALR
                landed[t] = 1'b1;
                i += 3;
            end else if (kind >= 11 && kind <= 13) begin
                lim = (room < 4) ? room : 4;
                t   = i + 1 + rand_below(lim);
                landed[t] = 1'b1;
                if (kind == 13) prog[i] = enc_j(21'((t - i) * 4), rd);
                else prog[i] = enc_b(13'((t - i) * 4), rs2, rs1, {2'b00, kind[0]});
                i++;
            end else begin
                if (kind <= 4) begin
                    case (sel)
                        0: prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd); // ADD
                        1: prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd); // SUB
                        2: prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                        3: prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                        4: prog[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
                        default: prog[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd); // SLT
                    endcase
                end else if (kind == 9) begin
                    prog[i] = {r[31:12], rd, 7'h37};   // LUI
                end else if (kind == 10) begin
                    prog[i] = {r[31:12], rd, 7'h17};   // AUIPC
                end else begin
                    case (sel % 4)
                        0: prog[i] = enc_i(r[11:0], rs1, 3'b000, rd, 7'h13);
                        1: prog[i] = enc_i(r[11:0], rs1, 3'b111, rd, 7'h13);
                        2: prog[i] = enc_i(r[11:0], rs1, 3'b110, rd, 7'h13);
                        default: prog[i] = enc_i(r[11:0], rs1, 3'b100, rd, 7'h13);
                    endcase
                end
                i++;
            end
        end
        prog[prog_len-1] = enc_j(21'd0, 5'd0); // Halt
    endtask

    task automatic model_reset();
        for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
        end
        model_pc       = '0;
        model_redirect = 1'b0;
    endtask

    // Executes the instruction at model_pc
    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        ins   = prog[model_pc[7:2]];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'b0};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        res   = '0;
        wr    = 1'b0;
        nxt   = model_pc + 32'd4;
        model_redirect = 1'b0;
        case (ins[6:0])
            7'h33, 7'h13: begin
                wr = 1'b1;
                if (!ins[5]) b = imm_i; // OP-IMM takes the immediate
                case (ins[14:12])
                    3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    3'b100:  res = a ^ b;
                    default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            7'h37: begin
                wr  = 1'b1;
                res = imm_u;
            end
            7'h17: begin
                wr  = 1'b1;
                res = model_pc + imm_u;
            end
            7'h63: begin
                if ((a == b) != ins[12]) begin // BEQ or BNE taken
                    nxt            = model_pc + imm_b;
                    model_redirect = 1'b1;
                end
            end
            7'h6f: begin
                wr             = 1'b1;
                res            = model_pc + 32'd4;
                nxt            = model_pc + imm_j;
                model_redirect = 1'b1;
            end
            7'h67: begin
                wr             = 1'b1;
                res            = model_pc + 32'd4;
                nxt            = (a + imm_i) & 32'hffff_fffe;
                model_redirect = 1'b1;
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) model_regs[ins[11:7]] = res;
        model_pc = nxt;
    endtask

    task automatic load_program();
        for (int a = 0; a < IMEM_WORDS; a++) begin
            @(posedge clk);
            #1;
            prog_valid_i = 1'b1;
            prog_addr_i  = 6'(a);
            prog_data_i  = prog[a];
            @(negedge clk);
            check_value("prog_ready_o", prog_ready_o, 32'd1); // Taken at the next edge
        end
    endtask

    // Follows retire pulses against the model until the halt retires
    task automatic run_and_check(input int first_gap);
        int   gap;
        int   retired;
        int   exp_gap;
        logic halted;
        gap     = 0;
        retired = 0;
        halted  = 1'b0;
        model_reset();
        while (!halted) begin
            @(negedge clk);
            gap++;
            check_value("prog_ready_o", prog_ready_o, 32'd0);
            if (retired > 0) check_value("a0_o", a0_o, model_regs[10]);
            if (retire_o) begin
                exp_gap = (retired == 0) ? first_gap : (model_redirect ? 2 : 1);
                check_value("retire gap", gap, exp_gap);
                check_value("retire_pc_o", retire_pc_o, model_pc);
                halted = (model_pc == halt_pc);
                model_step();
                retired++;
                gap = 0;
            end else if (gap > 2) begin
                check_value("retire_o", retire_o, 32'd1); // Pulse overdue
            end
        end
        @(negedge clk);
        check_value("a0_o", a0_o, model_regs[10]);
    endtask

    initial begin
        rst          = 1'b1;
        trigger_i    = 1'b0;
        prog_valid_i = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = '0;
        error_count  = 0;
        rng_state    = 32'ha195_db46;
        build_program();
        // Two runs plus load, resets and margin
        timeout_ns = 2 * (prog_len + 20) * 2 * CLK_NS
                   + (IMEM_WORDS + 3 * RST_CYCLES + 10) * CLK_NS;
        fork
            begin
                #(timeout_ns);
                $display("Timeout: the program did not reach its halt instruction");
                $display("Test failures found");
                $fatal(1);
            end
        join_none

        // First run, trigger low through reset
        repeat (RST_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("retire_o", retire_o, 32'd0);
        check_value("prog_ready_o", prog_ready_o, 32'd1);
        @(posedge clk);
        #1 rst = 1'b0;
        load_program();
        @(posedge clk);
        #1;
        prog_valid_i = 1'b0;
        trigger_i    = 1'b1;
        @(posedge clk);                 // Trigger sampled here
        #1;
        trigger_i    = 1'b0;
        prog_valid_i = 1'b1;            // Late write, must be ignored
        prog_addr_i  = '0;
        prog_data_i  = enc_j(21'd20, 5'd10); // Offset the generator never uses at word 0
        run_and_check(2);

        // Second run, trigger held through reset, program kept
        @(posedge clk);
        #1;
        prog_valid_i = 1'b0;
        trigger_i    = 1'b1;            // Set before reset so the latch sees it
        rst          = 1'b1;
        repeat (RST_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("retire_o", retire_o, 32'd0);
        check_value("prog_ready_o", prog_ready_o, 32'd0);
        @(posedge clk);
        #1;
        rst       = 1'b0;
        trigger_i = 1'b0;
        run_and_check(2);               // Fetch at the first edge out of reset

        if (error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
